//--- flist.f
hdl/stepper_pkg.sv
hdl/stepper_config.sv
hdl/microstep_sequencer.sv
hdl/chopper_timers.sv
hdl/microstepper_control.sv
hdl/stepper_top.sv
tests/stepper_checker.sv
tests/tb_stepper.sv

//--- hdl/chopper_timers.sv
module chopper_timers
  import stepper_pkg::*;
(
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 enable_r,
  input  stepper_cfg_t         cfg,
  input  logic [1:0]           offtimer_start,
  input  logic [1:0]           coil_change,
  output bridge_timers_t [1:0] timers
);

  logic enable_d;
  logic enable_rise;

  // Blanking also restarts when the bridges come out of disable
  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable_d <= 1'b0;
    end else begin
      enable_d <= enable_r;
    end
  end

  assign enable_rise = enable_r && !enable_d;

  for (genvar b = 0; b < 2; b++) begin : g_bridge
    bridge_timers_t t;

    always_ff @(posedge clk) begin
      if (!resetn || !enable_r) begin
        t <= '0;
      end else begin
        // Off time runs from the peak-current trip
        if (offtimer_start[b]) begin
          t.off_timer <= cfg.off_time;
        end else if (t.off_timer != '0) begin
          t.off_timer <= t.off_timer - off_time_t'(1);
        end

        // Minimum on time starts as the off time expires
        if (t.off_timer == off_time_t'(1)) begin
          t.minon_timer <= cfg.minon_time;
        end else if (t.minon_timer != '0) begin
          t.minon_timer <= t.minon_timer - short_time_t'(1);
        end

        // Masks the comparator after a coil current reversal
        if (coil_change[b] || enable_rise) begin
          t.blank_timer <= cfg.blank_time;
        end else if (t.blank_timer != '0) begin
          t.blank_timer <= t.blank_timer - short_time_t'(1);
        end
      end
    end

    assign timers[b] = t;

    // Start decision comes from the control block
    a_no_reload: assert property (
      @(posedge clk) disable iff (!resetn)
      (enable_r && offtimer_start[b]) |-> (t.off_timer == '0)
    );
  end

endmodule

//--- hdl/microstep_sequencer.sv
module microstep_sequencer
  import stepper_pkg::*;
(
  input  logic           clk,
  input  logic           resetn,
  input  logic           step,
  input  logic           dir,
  output phase_t         phase_ct,
  output coil_polarity_t polarity,
  output logic [1:0]     coil_change
);

  // Two sync stages plus one edge-detect stage for step
  logic [2:0]     step_r;
  logic [1:0]     dir_r;
  logic           step_rising;
  phase_t         phase_q;
  logic [1:0]     quadrant;
  coil_polarity_t polarity_d;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_r <= '0;
      dir_r  <= '0;
    end else begin
      step_r <= {step_r[1:0], step};
      dir_r  <= {dir_r[0], dir};
    end
  end

  assign step_rising = step_r[1] && !step_r[2];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase_q <= '0;
    end else if (step_rising) begin
      phase_q <= dir_r[1] ? phase_q + phase_t'(1) : phase_q - phase_t'(1);
    end
  end

  assign phase_ct = phase_q;
  assign quadrant = phase_q[7:6];

  // Bridge A is positive in quadrants 0 and 3, bridge B in 0 and 1
  always_comb begin
    polarity.s1 = (quadrant == 2'd0) || (quadrant == 2'd3);
    polarity.s2 = !polarity.s1;
    polarity.s3 = (quadrant == 2'd0) || (quadrant == 2'd1);
    polarity.s4 = !polarity.s3;
  end

  // Previous polarity, reset to the quadrant 0 pattern
  always_ff @(posedge clk) begin
    if (!resetn) begin
      polarity_d <= 4'b1010;
    end else begin
      polarity_d <= polarity;
    end
  end

  assign coil_change[0] = {polarity.s1, polarity.s2} != {polarity_d.s1, polarity_d.s2};
  assign coil_change[1] = {polarity.s3, polarity.s4} != {polarity_d.s3, polarity_d.s4};

  a_phase_single_step: assert property (
    @(posedge clk) disable iff (!resetn)
    (phase_ct != $past(phase_ct)) |->
      (phase_ct == phase_t'($past(phase_ct) + phase_t'(1)) ||
       phase_ct == phase_t'($past(phase_ct) - phase_t'(1)))
  );

endmodule

//--- hdl/microstepper_control.sv
module microstepper_control
  import stepper_pkg::*;
(
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 enable,
  input  stepper_cfg_t         cfg,
  input  coil_polarity_t       polarity,
  input  bridge_timers_t [1:0] timers,
  input  logic [1:0]           analog_cmp,
  output logic                 enable_r,
  output logic [1:0]           offtimer_start,
  output gate_drive_t          gates,
  output logic                 faultn
);

  logic [1:0] fast_decay;
  logic [1:0] slow_decay;
  logic [1:0] fault_set;
  // Legs in gate order a1, a2, b1, b2
  logic [3:0] pol_vec;
  logic [3:0] fast_vec;
  logic [3:0] slow_vec;
  logic [3:0] drive_pol;
  logic [3:0] high_pre;
  logic [3:0] low_pre;
  logic [3:0] high_out;
  logic [3:0] low_out;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable_r <= 1'b0;
    end else begin
      enable_r <= enable;
    end
  end

  for (genvar b = 0; b < 2; b++) begin : g_bridge
    // Early part of the off time decays fast, the rest slow
    assign fast_decay[b] = (timers[b].off_timer != '0) &&
                           (timers[b].off_timer >= cfg.fastdecay_threshold);
    assign slow_decay[b] = (timers[b].off_timer != '0) &&
                           (timers[b].off_timer < cfg.fastdecay_threshold);

    // Peak current reached outside blanking and off time
    assign offtimer_start[b] = analog_cmp[b] && (timers[b].blank_timer == '0) &&
                               (timers[b].off_timer == '0);

    // Off time running while minimum on is still pending
    assign fault_set[b] = enable_r && (timers[b].off_timer != '0) &&
                          (timers[b].minon_timer != '0);
  end

  // Latched until reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if (fault_set != 2'b00) begin
      faultn <= 1'b0;
    end
  end

  assign pol_vec  = {polarity.s1, polarity.s2, polarity.s3, polarity.s4};
  assign fast_vec = {fast_decay[0], fast_decay[0], fast_decay[1], fast_decay[1]};
  assign slow_vec = {slow_decay[0], slow_decay[0], slow_decay[1], slow_decay[1]};

  // Fast decay reverses the bridge
  assign drive_pol = pol_vec ^ fast_vec;

  // Slow decay recirculates through the low sides
  assign high_pre = ~slow_vec & drive_pol;
  assign low_pre  = slow_vec | ~drive_pol;

  // Disabled bridges short the coil low, a fault only drops the high sides
  assign high_out = high_pre & {4{faultn && enable_r}};
  assign low_out  = low_pre | {4{!enable_r}};

  assign gates = {high_out ^ {4{cfg.invert_highside}},
                  low_out ^ {4{cfg.invert_lowside}}};

  // Every leg is always driven one way or the other
  a_no_float: assert property (
    @(posedge clk) disable iff (!resetn)
    (high_pre | low_pre) == 4'hf
  );

endmodule

//--- hdl/stepper_config.sv
module stepper_config
  import stepper_pkg::*;
#(
  parameter int CFG_DATA_W = 16
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  cfg_wr,
  input  cfg_addr_e             cfg_addr,
  input  logic [CFG_DATA_W-1:0] cfg_wdata,
  output stepper_cfg_t          cfg
);

  // Power-on defaults
  localparam off_time_t   DEF_THRESHOLD = 10'd706;
  localparam off_time_t   DEF_OFF_TIME  = 10'd1000;
  localparam short_time_t DEF_BLANK     = 8'd20;
  localparam short_time_t DEF_MINON     = 8'd40;

  stepper_cfg_t cfg_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cfg_q.fastdecay_threshold <= DEF_THRESHOLD;
      cfg_q.off_time            <= DEF_OFF_TIME;
      cfg_q.blank_time          <= DEF_BLANK;
      cfg_q.minon_time          <= DEF_MINON;
      cfg_q.invert_highside     <= 1'b0;
      cfg_q.invert_lowside      <= 1'b0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        REG_FASTDECAY: begin
          cfg_q.fastdecay_threshold <= off_time_t'(cfg_wdata);
        end
        REG_OFFTIME: begin
          cfg_q.off_time <= off_time_t'(cfg_wdata);
        end
        REG_BLANK_MINON: begin
          // Low byte is blank, high byte is minimum-on
          cfg_q.blank_time <= short_time_t'(cfg_wdata);
          cfg_q.minon_time <= short_time_t'(cfg_wdata >> 8);
        end
        REG_CONTROL: begin
          cfg_q.invert_highside <= cfg_wdata[0];
          cfg_q.invert_lowside  <= cfg_wdata[1];
        end
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  assign cfg = cfg_q;

  // A write must always target a defined register
  a_addr_known: assert property (
    @(posedge clk) disable iff (!resetn)
    cfg_wr |-> !$isunknown(cfg_addr)
  );

endmodule

//--- hdl/stepper_pkg.sv
package stepper_pkg;

  // Microstep phase, top two bits select the electrical quadrant
  typedef logic [7:0] phase_t;

  // Off-timer count and fast-decay threshold
  typedef logic [9:0] off_time_t;

  // Blank and minimum-on counts
  typedef logic [7:0] short_time_t;

  // Configuration register map
  typedef enum logic [1:0] {
    REG_FASTDECAY   = 2'd0,
    REG_OFFTIME     = 2'd1,
    REG_BLANK_MINON = 2'd2,
    REG_CONTROL     = 2'd3
  } cfg_addr_e;

  typedef struct packed {
    off_time_t   fastdecay_threshold;
    off_time_t   off_time;
    short_time_t blank_time;
    short_time_t minon_time;
    logic        invert_highside;
    logic        invert_lowside;
  } stepper_cfg_t;

  // s1/s2 drive bridge A, s3/s4 drive bridge B
  typedef struct packed {
    logic s1;
    logic s2;
    logic s3;
    logic s4;
  } coil_polarity_t;

  typedef struct packed {
    off_time_t   off_timer;
    short_time_t blank_timer;
    short_time_t minon_timer;
  } bridge_timers_t;

  typedef struct packed {
    logic a1_h;
    logic a2_h;
    logic b1_h;
    logic b2_h;
    logic a1_l;
    logic a2_l;
    logic b1_l;
    logic b2_l;
  } gate_drive_t;

endpackage

//--- hdl/stepper_top.sv
module stepper_top
  import stepper_pkg::*;
#(
  parameter int CFG_DATA_W = 16
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  cfg_wr,
  input  cfg_addr_e             cfg_addr,
  input  logic [CFG_DATA_W-1:0] cfg_wdata,
  input  logic                  step,
  input  logic                  dir,
  input  logic                  enable,
  input  logic [1:0]            analog_cmp,
  output gate_drive_t           gates,
  output logic                  faultn,
  output phase_t                phase_ct
);

  stepper_cfg_t         cfg;
  coil_polarity_t       polarity;
  logic [1:0]           coil_change;
  logic [1:0]           offtimer_start;
  bridge_timers_t [1:0] timers;
  logic                 enable_r;

  stepper_config #(
    .CFG_DATA_W (CFG_DATA_W)
  ) u_config (
    .clk       (clk),
    .resetn    (resetn),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  microstep_sequencer u_sequencer (
    .clk         (clk),
    .resetn      (resetn),
    .step        (step),
    .dir         (dir),
    .phase_ct    (phase_ct),
    .polarity    (polarity),
    .coil_change (coil_change)
  );

  chopper_timers u_timers (
    .clk            (clk),
    .resetn         (resetn),
    .enable_r       (enable_r),
    .cfg            (cfg),
    .offtimer_start (offtimer_start),
    .coil_change    (coil_change),
    .timers         (timers)
  );

  microstepper_control u_control (
    .clk            (clk),
    .resetn         (resetn),
    .enable         (enable),
    .cfg            (cfg),
    .polarity       (polarity),
    .timers         (timers),
    .analog_cmp     (analog_cmp),
    .enable_r       (enable_r),
    .offtimer_start (offtimer_start),
    .gates          (gates),
    .faultn         (faultn)
  );

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_stepper -f flist.f -o tb_stepper; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_stepper > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1

//--- tests/stepper_checker.sv
module stepper_checker
  import stepper_pkg::*;
(
  input  logic         clk,
  input  gate_drive_t  gates,
  input  logic         faultn,
  input  phase_t       phase_ct,
  input  logic [127:0] exp_name,
  input  gate_drive_t  exp_gates,
  input  phase_t       exp_phase,
  input  logic         exp_faultn,
  input  logic         chk,
  input  logic         test_done,
  output int           err_count,
  output int           check_count,
  output int           test_count
);
  timeunit 1ns;
  timeprecision 100ps;

  int errs = 0;
  int checks = 0;
  int tests = 0;
  int test_errs = 0;

  assign err_count   = errs;
  assign check_count = checks;
  assign test_count  = tests;

  task automatic compare(input string what, input logic [7:0] expv, input logic [7:0] actv);
    if (actv !== expv) begin
      $display("Error %0s %0s: expected %h, actual %h", exp_name, what, expv, actv);
      errs++;
      test_errs++;
    end
  endtask

  // Values sampled here were settled by the previous rising edge
  always @(posedge clk) begin
    if (chk) begin
      checks++;
      compare("gates", exp_gates, gates);
      compare("phase_ct", exp_phase, phase_ct);
      compare("faultn", 8'(exp_faultn), 8'(faultn));
    end
    if (test_done) begin
      tests++;
      if (test_errs == 0) begin
        $display("Test %0s: ok", exp_name);
      end else begin
        $display("Test %0s: %0d mismatches", exp_name, test_errs);
      end
      test_errs = 0;
    end
  end

endmodule

//--- tests/tb_stepper.sv
module tb_stepper
  import stepper_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {ACT_RST, ACT_WR, ACT_STEP, ACT_EN, ACT_CMP, ACT_WAIT} act_e;

  // One table row: action, operands and the values expected afterwards
  typedef struct packed {
    logic [127:0] name;
    act_e         act;
    logic [1:0]   sel;
    logic [15:0]  arg;
    logic         chk;
    logic [7:0]   gates;
    logic         faultn;
  } row_t;

  // Step direction select
  localparam logic [1:0] BACK = 2'd0;
  localparam logic [1:0] FWD  = 2'd1;
  localparam logic [1:0] RAND = 2'd2;

  logic        clk = 1'b0;
  logic        resetn;
  logic        cfg_wr;
  cfg_addr_e   cfg_addr;
  logic [15:0] cfg_wdata;
  logic        step;
  logic        dir;
  logic        enable;
  logic [1:0]  analog_cmp;
  gate_drive_t gates;
  logic        faultn;
  phase_t      phase_ct;

  // Expected values handed to the checker
  logic [127:0] exp_name;
  gate_drive_t  exp_gates;
  phase_t       exp_phase;
  logic         exp_faultn;
  logic         chk;
  logic         test_done;
  int           err_count;
  int           check_count;
  int           test_count;

  row_t        rows[$];
  phase_t      phase_model;
  logic [31:0] rng = 32'd77587;
  int          cycles = 0;
  int          limit;

  always #2 clk = ~clk;

  stepper_top #(
    .CFG_DATA_W (16)
  ) DUT (
    .clk        (clk),
    .resetn     (resetn),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .step       (step),
    .dir        (dir),
    .enable     (enable),
    .analog_cmp (analog_cmp),
    .gates      (gates),
    .faultn     (faultn),
    .phase_ct   (phase_ct)
  );

  stepper_checker u_checker (
    .clk         (clk),
    .gates       (gates),
    .faultn      (faultn),
    .phase_ct    (phase_ct),
    .exp_name    (exp_name),
    .exp_gates   (exp_gates),
    .exp_phase   (exp_phase),
    .exp_faultn  (exp_faultn),
    .chk         (chk),
    .test_done   (test_done),
    .err_count   (err_count),
    .check_count (check_count),
    .test_count  (test_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int row_cycles(input row_t r);
    case (r.act)
      ACT_RST:  return 2;
      ACT_STEP: return 5 * int'(r.arg);
      ACT_WAIT: return int'(r.arg);
      default:  return 1;
    endcase
  endfunction

  task automatic add(input logic [127:0] name, input act_e act, input logic [1:0] sel,
                     input logic [15:0] arg, input logic chk_en, input logic [7:0] g,
                     input logic f);
    row_t r;
    r = '{name, act, sel, arg, chk_en, g, f};
    rows.push_back(r);
  endtask

  // Gate codes {a1_h,a2_h,b1_h,b2_h,a1_l,a2_l,b1_l,b2_l}
  // q0 A5, q1 69, q2 5A, q3 96, slow or disabled 0F, q0 fast 5A
  task automatic build_table();
    logic [15:0] count;
    rng = xorshift32(rng);
    count = 16'd16 + {12'd0, rng[3:0]};
    add("reset_state", ACT_RST, 2'd0, 16'd0, 1'b1, 8'h0F, 1'b1);
    add("step_counting", ACT_STEP, RAND, count, 1'b1, 8'h0F, 1'b1);
    add("polarity_drive", ACT_RST, 2'd0, 16'd0, 1'b0, 8'h0F, 1'b1);
    add("polarity_drive", ACT_EN, 2'd0, 16'd1, 1'b1, 8'hA5, 1'b1);
    add("polarity_drive", ACT_STEP, BACK, 16'd1, 1'b1, 8'h96, 1'b1);
    add("polarity_drive", ACT_STEP, BACK, 16'd64, 1'b1, 8'h5A, 1'b1);
    add("polarity_drive", ACT_STEP, BACK, 16'd64, 1'b1, 8'h69, 1'b1);
    add("fixed_off_time", ACT_RST, 2'd0, 16'd0, 1'b0, 8'h0F, 1'b1);
    add("fixed_off_time", ACT_WR, REG_FASTDECAY, 16'd6, 1'b0, 8'h0F, 1'b1);
    add("fixed_off_time", ACT_WR, REG_OFFTIME, 16'd10, 1'b0, 8'h0F, 1'b1);
    add("fixed_off_time", ACT_WR, REG_BLANK_MINON, 16'h0002, 1'b0, 8'h0F, 1'b1);
    add("fixed_off_time", ACT_EN, 2'd0, 16'd1, 1'b1, 8'hA5, 1'b1);
    add("fixed_off_time", ACT_WAIT, 2'd0, 16'd4, 1'b1, 8'hA5, 1'b1);
    add("fixed_off_time", ACT_CMP, 2'd0, 16'd3, 1'b1, 8'h5A, 1'b1);
    add("fixed_off_time", ACT_WAIT, 2'd0, 16'd3, 1'b1, 8'h5A, 1'b1);
    add("fixed_off_time", ACT_CMP, 2'd0, 16'd0, 1'b1, 8'h5A, 1'b1);
    add("fixed_off_time", ACT_WAIT, 2'd0, 16'd5, 1'b1, 8'h0F, 1'b1);
    add("fixed_off_time", ACT_WAIT, 2'd0, 16'd2, 1'b1, 8'hA5, 1'b1);
    add("inversion", ACT_STEP, BACK, 16'd1, 1'b1, 8'h96, 1'b1);
    add("inversion", ACT_WR, REG_CONTROL, 16'd1, 1'b1, 8'h66, 1'b1);
    add("inversion", ACT_WR, REG_CONTROL, 16'd2, 1'b1, 8'h99, 1'b1);
    add("inversion", ACT_WR, REG_CONTROL, 16'd0, 1'b1, 8'h96, 1'b1);
    add("inversion", ACT_STEP, FWD, 16'd65, 1'b1, 8'h69, 1'b1);
    add("inversion", ACT_WR, REG_CONTROL, 16'd1, 1'b1, 8'h99, 1'b1);
    add("inversion", ACT_WR, REG_CONTROL, 16'd2, 1'b1, 8'h66, 1'b1);
    add("inversion", ACT_WR, REG_CONTROL, 16'd0, 1'b1, 8'h69, 1'b1);
    add("fault_latch", ACT_RST, 2'd0, 16'd0, 1'b0, 8'h0F, 1'b1);
    add("fault_latch", ACT_WR, REG_FASTDECAY, 16'd6, 1'b0, 8'h0F, 1'b1);
    add("fault_latch", ACT_WR, REG_OFFTIME, 16'd10, 1'b0, 8'h0F, 1'b1);
    add("fault_latch", ACT_WR, REG_BLANK_MINON, 16'h2802, 1'b0, 8'h0F, 1'b1);
    add("fault_latch", ACT_EN, 2'd0, 16'd1, 1'b1, 8'hA5, 1'b1);
    add("fault_latch", ACT_WAIT, 2'd0, 16'd4, 1'b1, 8'hA5, 1'b1);
    add("fault_latch", ACT_CMP, 2'd0, 16'd3, 1'b1, 8'h5A, 1'b1);
    add("fault_latch", ACT_WAIT, 2'd0, 16'd4, 1'b1, 8'h5A, 1'b1);
    add("fault_latch", ACT_WAIT, 2'd0, 16'd5, 1'b1, 8'h0F, 1'b1);
    // Off time over, minimum-on starts and the comparator is still high
    add("fault_latch", ACT_WAIT, 2'd0, 16'd1, 1'b1, 8'hA5, 1'b1);
    add("fault_latch", ACT_WAIT, 2'd0, 16'd1, 1'b1, 8'h5A, 1'b1);
    add("fault_latch", ACT_WAIT, 2'd0, 16'd1, 1'b1, 8'h0A, 1'b0);
    add("fault_latch", ACT_CMP, 2'd0, 16'd0, 1'b1, 8'h0A, 1'b0);
    add("fault_latch", ACT_WAIT, 2'd0, 16'd20, 1'b0, 8'h05, 1'b0);
    add("fault_latch", ACT_WAIT, 2'd0, 16'd2, 1'b1, 8'h05, 1'b0);
    add("fault_latch", ACT_RST, 2'd0, 16'd0, 1'b1, 8'h0F, 1'b1);
  endtask

  task automatic tick();
    @(negedge clk);
    chk = 1'b0;
    test_done = 1'b0;
  endtask

  task automatic post(input row_t r, input logic done);
    exp_name   = r.name;
    exp_gates  = r.gates;
    exp_phase  = phase_model;
    exp_faultn = r.faultn;
    chk        = r.chk;
    test_done  = done;
  endtask

  // Two cycles high, three low
  task automatic step_once(input logic d);
    step = 1'b1;
    dir  = d;
    tick();
    tick();
    step = 1'b0;
    tick();
    tick();
    tick();
    phase_model = d ? phase_model + phase_t'(1) : phase_model - phase_t'(1);
  endtask

  task automatic run_row(input row_t r);
    logic d;
    case (r.act)
      ACT_RST: begin
        resetn      = 1'b0;
        cfg_wr      = 1'b0;
        step        = 1'b0;
        dir         = 1'b0;
        enable      = 1'b0;
        analog_cmp  = 2'b00;
        phase_model = '0;
        tick();
        tick();
        resetn = 1'b1;
      end
      ACT_WR: begin
        cfg_wr    = 1'b1;
        cfg_addr  = cfg_addr_e'(r.sel);
        cfg_wdata = r.arg;
        tick();
        cfg_wr = 1'b0;
      end
      ACT_STEP: begin
        for (int k = 0; k < int'(r.arg); k++) begin
          d = r.sel[0];
          if (r.sel == RAND) begin
            // First random step goes down so the counter wraps below 0
            rng = xorshift32(rng);
            d = (k == 0) ? 1'b0 : rng[16];
          end
          step_once(d);
        end
      end
      ACT_EN: begin
        enable = r.arg[0];
        tick();
      end
      ACT_CMP: begin
        analog_cmp = r.arg[1:0];
        tick();
      end
      ACT_WAIT: begin
        for (int k = 1; k < int'(r.arg); k++) begin
          tick();
          post(r, 1'b0);
        end
        tick();
      end
    endcase
  endtask

  initial begin
    int   total;
    logic last;
    resetn      = 1'b0;
    cfg_wr      = 1'b0;
    cfg_addr    = REG_FASTDECAY;
    cfg_wdata   = '0;
    step        = 1'b0;
    dir         = 1'b0;
    enable      = 1'b0;
    analog_cmp  = 2'b00;
    exp_name    = '0;
    exp_gates   = '0;
    exp_phase   = '0;
    exp_faultn  = 1'b1;
    chk         = 1'b0;
    test_done   = 1'b0;
    phase_model = '0;
    build_table();
    total = 0;
    foreach (rows[i]) begin
      total += row_cycles(rows[i]);
    end
    limit = total + 100;
    for (int i = 0; i < rows.size(); i++) begin
      run_row(rows[i]);
      last = 1'b1;
      if (i < rows.size() - 1) begin
        last = rows[i + 1].name != rows[i].name;
      end
      post(rows[i], rows[i].chk && last);
    end
    tick();
    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0 && check_count > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: stimulus did not finish within %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule
